// File: test/bus_stimulus.txt
# kind(0 mrd 1 mwr 2 iord 3 iowr 4 m1) addr wdata waits rdata rfsh_after
# rdata is ignored on write rows, all fields hex except waits
1 1234 a5 0 00 00
0 1234 00 0 a5 00
2 0056 00 0 56 00
2 ab12 00 0 b9 00
0 3c0f 00 2 33 00
3 0020 5a 0 00 00
2 0020 00 1 5a 00
4 0100 00 0 01 01
4 4142 00 3 03 02
1 2008 c3 1 00 02
4 2008 00 0 c3 03
0 00ff 00 0 ff 03
4 7f80 00 2 ff 04
0 1234 00 1 a5 04
3 1234 77 0 00 04
2 1234 00 0 77 04
0 1234 00 0 a5 04
4 1234 00 1 a5 05

// File: tb.f
+incdir+hdl
hdl/pins_pkg.sv
hdl/bus_cycle_sequencer.sv
hdl/address_pins.sv
hdl/data_pins.sv
hdl/bus_interface_top.sv
test/bus_interface_properties.sv
test/tb_bus_interface.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the bus interface testbench with Verilator
set -u

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert --top-module tb_bus_interface \
    -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation passed"
exit 0

// File: test/tb_bus_interface.sv
// Needs test/bus_stimulus.txt under the run directory. Memory model aliases on address bits 4..0
`timescale 1ns/1ps
`default_nettype none

`include "pins_macros.svh"

module tb_bus_interface;
    import pins_pkg::*;

    localparam int TIMEOUT_CYCLES = 40;             // Longest cycle plus margin

    logic                    clk;
    logic                    arst_n;
    logic                    start;
    cycle_kind_t             cycle_kind;
    addr_t                   addr;
    data_t                   wdata;
    logic                    busy;
    logic                    done;
    data_t                   rdata;
    logic [`PINS_RFSH_W-1:0] rfsh_addr;
    addr_t                   apin;
    logic                    apin_oe;
    data_t                   dpin_out;
    logic                    dpin_oe;
    data_t                   dpin_in = '0;          // Driven by the memory model
    logic                    mreq_n;
    logic                    iorq_n;
    logic                    rd_n;
    logic                    wr_n;
    logic                    m1_n;
    logic                    rfsh_n;
    logic                    wait_n;

    int    errors;
    int    timeouts;
    int    seed;
    data_t mem_data [64];                           // Sparse memory and I/O space
    bit    mem_valid [64];
    logic  wr_seen;                                 // Write strobe low last sample
    addr_t wr_addr;
    data_t wr_data;
    logic  wr_io;
    data_t last_rd;                                 // Byte of the last read, kept by writes

    bus_interface_top dut_i
    (
        .clk, .arst_n, .start, .cycle_kind, .addr, .wdata, .busy, .done, .rdata, .rfsh_addr,
        .apin, .apin_oe, .dpin_out, .dpin_oe, .dpin_in,
        .mreq_n, .iorq_n, .rd_n, .wr_n, .m1_n, .rfsh_n, .wait_n
    );

    always #4 clk = ~clk;                           // 8 ns period

    // --------------------------------------------------
    // Memory and I/O model
    // --------------------------------------------------

    function automatic logic [5:0] mem_index(input addr_t a, input logic io);
        return {io, a[4:0]};                        // I/O and memory kept apart
    endfunction

    function automatic data_t mem_read(input addr_t a, input logic io);
        logic [5:0] idx;
        idx = mem_index(a, io);
        if (mem_valid[idx])
            return mem_data[idx];
        return a[7:0] ^ a[15:8];                    // Unwritten location rule
    endfunction

    always @(posedge clk)
    begin
        #1;
        if (!rd_n && rfsh_n)
            dpin_in = mem_read(apin, !iorq_n);      // Bus read in progress
        else
            dpin_in = '0;
        if (!wr_n)
        begin
            wr_seen = 1'b1;
            wr_addr = apin;
            wr_data = dpin_out;
            wr_io   = !iorq_n;
        end
        else if (wr_seen)
        begin
            mem_data[mem_index(wr_addr, wr_io)]  = wr_data;     // Rising edge of wr_n
            mem_valid[mem_index(wr_addr, wr_io)] = 1'b1;
            wr_seen = 1'b0;
        end
    end

    // --------------------------------------------------
    // One bus request with its checks
    // --------------------------------------------------

    task automatic run_request(input int kind_v, input int addr_v, input int wdata_v,
                               input int waits, input int exp_rdata, input int exp_rfsh,
                               input string name);
        int                      n;
        int                      expect_n;
        logic                    seen_done;
        logic                    is_io;
        logic                    is_m1;
        logic                    is_wr;
        logic                    is_t4;
        logic                    exp_busy;
        logic [8:0]              exp_pins;
        logic [8:0]              act_pins;
        data_t                   exp_rd;
        logic [`PINS_RFSH_W-1:0] rf_prev;
        cycle_kind_t             k;
        k         = cycle_kind_t'(kind_v[2:0]);
        is_io     = (k == CYC_IO_RD) || (k == CYC_IO_WR);
        is_m1     = (k == CYC_M1);
        is_wr     = (k == CYC_MEM_WR) || (k == CYC_IO_WR);
        expect_n  = (is_m1 ? 5 : 4) + waits;        // Baseline plus wait states
        rf_prev   = exp_rfsh[6:0] - 7'd1;           // Count shown in T_4
        exp_rd    = is_wr ? last_rd : exp_rdata[7:0];   // Writes leave rdata alone
        seen_done = 1'b0;
        n         = 0;
        @(posedge clk);
        #1;
        start      = 1'b1;
        cycle_kind = k;
        addr       = addr_v[15:0];
        wdata      = wdata_v[7:0];
        wait_n     = 1'b1;
        while (!seen_done && n < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            #1;
            n++;
            if (n == 1)
            begin
                start = 1'b0;
                if (waits > 0)
                    wait_n = 1'b0;                  // Sampled first at the end of T_2
            end
            if (waits > 0 && n == 2 + waits)
                wait_n = 1'b1;
            if (n == 2)
            begin
                start      = 1'b1;                  // Stray request while busy
                cycle_kind = CYC_MEM_WR;
                addr       = addr_t'($random(seed));
            end
            if (n == 3)
            begin
                start = 1'b0;
                addr  = addr_v[15:0];
            end
            // T_1 is n 1, T_2 repeats up to n 2 + waits, T_4 of an M1 follows T_3
            is_t4    = is_m1 && (n == 4 + waits);
            exp_busy = (n < expect_n);
            exp_pins = {exp_busy,                               // busy
                        exp_busy,                               // apin_oe, T_4 too
                        is_wr && n <= 3 + waits,                // dpin_oe
                        !(exp_busy && !is_io),                  // mreq_n
                        !(exp_busy && is_io),                   // iorq_n
                        !(!is_wr && n <= 3 + waits),            // rd_n, T_1 to T_3
                        !(is_wr && n >= 2 && n <= 3 + waits),   // wr_n, T_2 and T_3
                        !(is_m1 && n <= 2 + waits),             // m1_n, T_1 and T_2
                        !is_t4};                                // rfsh_n
            act_pins = {busy, apin_oe, dpin_oe, mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n};
            assert (act_pins == exp_pins) else
            begin
                errors++;
                $display("FAIL %s pins in cycle %0d: expected %b, actual %b",
                         name, n, exp_pins, act_pins);
            end
            if (is_t4)
            begin
                assert (apin == {{`PINS_RFSH_PAD_W{1'b0}}, rf_prev}) else
                begin
                    errors++;
                    $display("FAIL %s refresh apin: expected %h, actual %h",
                             name, {{`PINS_RFSH_PAD_W{1'b0}}, rf_prev}, apin);
                end
            end
            else if (exp_busy)
            begin
                assert (apin == addr_v[15:0]) else
                begin
                    errors++;
                    $display("FAIL %s apin: expected %h, actual %h", name, addr_v[15:0], apin);
                end
            end
            if (done)
            begin
                seen_done = 1'b1;
                assert (n == expect_n) else
                begin
                    errors++;
                    $display("FAIL %s latency: expected %0d, actual %0d", name, expect_n, n);
                end
                assert (rdata == exp_rd) else
                begin
                    errors++;
                    $display("FAIL %s rdata: expected %h, actual %h", name, exp_rd, rdata);
                end
                assert (rfsh_addr == exp_rfsh[6:0]) else
                begin
                    errors++;
                    $display("FAIL %s rfsh_addr: expected %h, actual %h",
                             name, exp_rfsh[6:0], rfsh_addr);
                end
            end
        end
        if (!seen_done)
        begin
            errors++;
            timeouts++;
            $display("Error: %s got no done within %0d cycles", name, TIMEOUT_CYCLES);
        end
        else
        begin
            last_rd = exp_rd;
            @(posedge clk);
            #1;
            assert (!busy) else
            begin
                errors++;
                $display("Error: %s the pulse sent while busy started a cycle", name);
            end
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial
    begin
        int    fd;
        int    cnt;
        int    kv;
        int    av;
        int    dv;
        int    wv;
        int    rv;
        int    fv;
        int    row;
        int    last_rfsh;
        int    i;
        string line;
        clk        = 1'b0;
        arst_n     = 1'b0;
        start      = 1'b0;
        cycle_kind = CYC_MEM_RD;
        addr       = '0;
        wdata      = '0;
        wait_n     = 1'b1;
        errors     = 0;
        timeouts   = 0;
        seed       = 32'h8d24_770a;
        wr_seen    = 1'b0;
        last_rd    = '0;                            // rdata after reset
        row        = 0;
        last_rfsh  = 0;
        for (i = 0; i < 64; i++)
        begin
            mem_valid[i] = 1'b0;
            mem_data[i]  = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (i = 0; i < 3; i++)                     // Idle cycles change nothing
        begin
            @(posedge clk);
            #1;
            assert ({mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n,
                     busy, done, apin_oe, dpin_oe, rfsh_addr} ==
                    {6'b111111, 4'b0000, {`PINS_RFSH_W{1'b0}}}) else
            begin
                errors++;
                $display("FAIL idle%0d: expected %b, actual %b", i,
                         {6'b111111, 4'b0000, {`PINS_RFSH_W{1'b0}}},
                         {mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n,
                          busy, done, apin_oe, dpin_oe, rfsh_addr});
            end
        end
        fd = $fopen("test/bus_stimulus.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("Error: cannot open the stimulus file");
        end
        else
        begin
            while (!$feof(fd) && timeouts == 0)
            begin
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.len() > 0 && line[0] != 8'h23)   // Skip # lines
                begin
                    if ($sscanf(line, "%h %h %h %d %h %h", kv, av, dv, wv, rv, fv) == 6)
                    begin
                        row++;
                        run_request(kv, av, dv, wv, rv, fv, $sformatf("row%0d", row));
                        last_rfsh = fv;
                    end
                end
            end
            $fclose(fd);
        end
        // Opcode fetches until the refresh counter wraps
        for (i = 0; i < 130 && timeouts == 0; i++)
        begin
            last_rfsh = (last_rfsh + 1) % 128;
            wv = {$random(seed)} % 3;
            run_request(4, {i[7:0], 8'h63}, 0, wv, 8'h63 ^ i[7:0], last_rfsh,
                        $sformatf("fetch%0d", i));
        end
        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/bus_interface_properties.sv
// Checks pin strobes only and is held off during reset
`timescale 1ns/1ps
`default_nettype none

module bus_interface_properties
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               mreq_n,
    input  logic               iorq_n,
    input  logic               rd_n,
    input  logic               wr_n,
    input  logic               m1_n,
    input  logic               rfsh_n,
    input  logic               dpin_oe,
    input  logic               done
);

    // --------------------------------------------------
    // Strobe rules
    // --------------------------------------------------

    assert property (@(posedge clk) disable iff (!arst_n) !(!mreq_n && !iorq_n))
        else $error("mreq_n and iorq_n low together");
    assert property (@(posedge clk) disable iff (!arst_n) !(!rd_n && !wr_n))
        else $error("rd_n and wr_n low together");
    assert property (@(posedge clk) disable iff (!arst_n) !(dpin_oe && !rd_n))
        else $error("data pins driven during a read");
    assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else $error("done longer than one cycle");
    assert property (@(posedge clk) disable iff (!arst_n) !rfsh_n |-> m1_n)
        else $error("rfsh_n and m1_n low together");

endmodule

bind bus_interface_top bus_interface_properties props_i
(
    .clk, .arst_n, .mreq_n, .iorq_n, .rd_n, .wr_n, .m1_n, .rfsh_n,
    .dpin_oe, .done
);

`default_nettype wire

// File: hdl/bus_interface_top.sv
// Split pins, no tri-states. The external side must honour apin_oe and dpin_oe
`timescale 1ns/1ps
`default_nettype none

`include "pins_macros.svh"

module bus_interface_top
(
    input  logic                    clk,
    input  logic                    arst_n,
    // Core side
    input  logic                    start,          // One-cycle request
    input  pins_pkg::cycle_kind_t   cycle_kind,
    input  pins_pkg::addr_t         addr,
    input  pins_pkg::data_t         wdata,
    output logic                    busy,
    output logic                    done,           // Pulse at the end of a cycle
    output pins_pkg::data_t         rdata,          // Valid with done on reads
    output logic [`PINS_RFSH_W-1:0] rfsh_addr,
    // Pin side
    output pins_pkg::addr_t         apin,
    output logic                    apin_oe,
    output pins_pkg::data_t         dpin_out,
    output logic                    dpin_oe,
    input  pins_pkg::data_t         dpin_in,
    output logic                    mreq_n,
    output logic                    iorq_n,
    output logic                    rd_n,
    output logic                    wr_n,
    output logic                    m1_n,
    output logic                    rfsh_n,
    input  logic                    wait_n
);

    // --------------------------------------------------
    // Sequencer to pin block wiring
    // --------------------------------------------------

    logic     ctl_ab_we;
    logic     ctl_ab_pin_oe;
    logic     ctl_ab_rfsh;
    logic     ctl_rfsh_inc;
    logic     ctl_db_we;
    logic     ctl_db_pin_re;
    logic     ctl_db_oe;
    logic     ctl_db_pin_oe;

    bus_cycle_sequencer bus_cycle_sequencer_inst
    (
        .clk, .arst_n, .start, .cycle_kind, .wait_n, .busy,
        .done    (),                                // Core done comes from data_pins
        .t_state (),
        .ctl_ab_we, .ctl_ab_pin_oe, .ctl_ab_rfsh, .ctl_rfsh_inc,
        .ctl_db_we, .ctl_db_pin_re, .ctl_db_oe, .ctl_db_pin_oe,
        .mreq_n, .iorq_n, .rd_n, .wr_n, .m1_n, .rfsh_n
    );

    address_pins address_pins_inst
    (
        .clk, .arst_n,
        .ab (addr),                                 // Core address into the latch
        .ctl_ab_we, .ctl_ab_pin_oe, .ctl_ab_rfsh, .ctl_rfsh_inc,
        .apin, .apin_oe, .rfsh_addr
    );

    data_pins data_pins_inst
    (
        .clk, .arst_n,
        .db_in (wdata),
        .dpin_in,
        .ctl_db_we, .ctl_db_pin_re, .ctl_db_oe, .ctl_db_pin_oe,
        .dpin_out, .dpin_oe,
        .db_out   (rdata),                          // Registered in step with done
        .db_valid (done)
    );

endmodule

`default_nettype wire

// File: hdl/data_pins.sv
// Pins read zero with dpin_oe low. db_out changes only for a byte that came in from the pins
`timescale 1ns/1ps
`default_nettype none

module data_pins
(
    input  logic            clk,
    input  logic            arst_n,
    input  pins_pkg::data_t db_in,                  // Core write data
    input  pins_pkg::data_t dpin_in,                // Data pins, input side
    input  logic            ctl_db_we,              // Load the latch from the core
    input  logic            ctl_db_pin_re,          // Load the latch from the pins
    input  logic            ctl_db_oe,              // Hand the latch to the core
    input  logic            ctl_db_pin_oe,          // Drive the data pins
    output pins_pkg::data_t dpin_out,               // Data pins, output side
    output logic            dpin_oe,                // Pin output enable
    output pins_pkg::data_t db_out,                 // Byte returned to the core
    output logic            db_valid                // db_out updated this cycle
);
    import pins_pkg::*;

    data_t db_q;                                    // Shared data latch
    logic  from_pins;                               // Latch holds read data

    // --------------------------------------------------
    // Data latch
    // --------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (ctl_db_we)
            db_q <= db_in;                          // Core side wins
        else if (ctl_db_pin_re)
            db_q <= dpin_in;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            from_pins <= 1'b0;
        else if (ctl_db_we)
            from_pins <= 1'b0;                      // Write data is never read back
        else if (ctl_db_pin_re)
            from_pins <= 1'b1;
    end

    // --------------------------------------------------
    // Core side read back
    // --------------------------------------------------

    // A read that ends in T_3 hands the byte over on the same edge that
    // captures it, so the pin value goes straight through in that case
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            db_out   <= '0;
            db_valid <= 1'b0;
        end
        else
        begin
            db_valid <= ctl_db_oe;                  // One cycle per request
            if (ctl_db_oe && ctl_db_pin_re)
                db_out <= dpin_in;
            else if (ctl_db_oe && from_pins)
                db_out <= db_q;                     // M1 path, captured a T-state earlier
        end
    end

    // --------------------------------------------------
    // Pin side
    // --------------------------------------------------

    assign dpin_out = ctl_db_pin_oe ? db_q : '0;
    assign dpin_oe  = ctl_db_pin_oe;

endmodule

`default_nettype wire

// File: hdl/address_pins.sv
// Pins read zero with apin_oe low. The refresh word has a zero upper byte (no I register)
`timescale 1ns/1ps
`default_nettype none

`include "pins_macros.svh"

module address_pins
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  pins_pkg::addr_t         ab,             // Core address bus
    input  logic                    ctl_ab_we,      // Load the address latch
    input  logic                    ctl_ab_pin_oe,  // Enable the pin drivers
    input  logic                    ctl_ab_rfsh,    // Select the refresh word
    input  logic                    ctl_rfsh_inc,   // Advance the refresh counter
    output pins_pkg::addr_t         apin,           // Address pins
    output logic                    apin_oe,        // Pin output enable
    output logic [`PINS_RFSH_W-1:0] rfsh_addr       // Current refresh count
);
    import pins_pkg::*;

    addr_t                   ab_q;                  // Latched request address
    addr_t                   rfsh_word;             // Counter placed in the low bits
    logic [`PINS_RFSH_W-1:0] rfsh_cnt;

    always_ff @(posedge clk)
    begin
        if (ctl_ab_we)
            ab_q <= ab;                             // Holds through the whole cycle
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            rfsh_cnt <= '0;
        else if (ctl_rfsh_inc)
            rfsh_cnt <= rfsh_cnt + 1'b1;            // Wraps after 127
    end

    assign rfsh_word = {{`PINS_RFSH_PAD_W{1'b0}}, rfsh_cnt};

    always_comb
    begin
        if (!ctl_ab_pin_oe)
            apin = '0;                              // Pins released
        else if (ctl_ab_rfsh)
            apin = rfsh_word;
        else
            apin = ab_q;
    end

    assign apin_oe   = ctl_ab_pin_oe;
    assign rfsh_addr = rfsh_cnt;

endmodule

`default_nettype wire

// File: hdl/bus_cycle_sequencer.sv
// One bus cycle at a time. Starts are taken only in T_IDLE and wait_n is sampled only at T_2 end
`timescale 1ns/1ps
`default_nettype none

module bus_cycle_sequencer
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,            // One-cycle request pulse
    input  pins_pkg::cycle_kind_t cycle_kind,       // Kind, valid with start
    input  logic                  wait_n,           // Low stretches T_2
    output logic                  busy,             // Cycle in flight
    output logic                  done,             // End of cycle pulse
    output pins_pkg::t_state_t    t_state,          // Current T-state
    output logic                  ctl_ab_we,        // Latch the core address
    output logic                  ctl_ab_pin_oe,    // Drive the address pins
    output logic                  ctl_ab_rfsh,      // Refresh address on pins
    output logic                  ctl_rfsh_inc,     // Step the refresh counter
    output logic                  ctl_db_we,        // Latch the core write data
    output logic                  ctl_db_pin_re,    // Capture the data pins
    output logic                  ctl_db_oe,        // Return the byte to the core
    output logic                  ctl_db_pin_oe,    // Drive the data pins
    output logic                  mreq_n,
    output logic                  iorq_n,
    output logic                  rd_n,
    output logic                  wr_n,
    output logic                  m1_n,
    output logic                  rfsh_n
);
    import pins_pkg::*;

    t_state_t    t_next;                // Next T-state
    cycle_kind_t kind_q;                // Kind of the cycle in flight
    cycle_kind_t kind_next;             // Kind seen by the next T-state
    logic        accept;                // Start taken this cycle
    logic        last_t;                // Final T-state of the cycle

    // --------------------------------------------------
    // Kind classes
    // --------------------------------------------------

    function automatic logic kind_reads(input cycle_kind_t k);
        return (k == CYC_MEM_RD) || (k == CYC_IO_RD) || (k == CYC_M1);
    endfunction

    function automatic logic kind_writes(input cycle_kind_t k);
        return (k == CYC_MEM_WR) || (k == CYC_IO_WR);
    endfunction

    function automatic logic kind_io(input cycle_kind_t k);
        return (k == CYC_IO_RD) || (k == CYC_IO_WR);
    endfunction

    // --------------------------------------------------
    // T-state machine
    // --------------------------------------------------

    assign busy   = (t_state != T_IDLE);            // Low again in the done cycle
    assign accept = start && !busy;                 // Starts while busy are dropped

    always_comb
    begin
        t_next = T_IDLE;
        case (t_state)
            T_IDLE: t_next = accept ? T_1 : T_IDLE;
            T_1:    t_next = T_2;
            T_2:    t_next = wait_n ? T_3 : T_2;    // Each low sample adds one T_2
            T_3:    t_next = (kind_q == CYC_M1) ? T_4 : T_IDLE;
            T_4:    t_next = T_IDLE;                // Refresh ends an M1 cycle
            default: t_next = T_IDLE;
        endcase
    end

    assign kind_next = accept ? cycle_kind : kind_q;
    assign last_t    = busy && (t_next == T_IDLE);  // T_3, or T_4 for M1

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            t_state <= T_IDLE;
            kind_q  <= CYC_MEM_RD;
            done    <= 1'b0;
        end
        else
        begin
            t_state <= t_next;
            kind_q  <= kind_next;
            done    <= last_t;                      // One cycle after the last T-state
        end
    end

    // --------------------------------------------------
    // Bus strobes, registered from the next T-state
    // --------------------------------------------------

    // Each strobe flop takes the value its T-state needs one edge early,
    // so the pins change on clock edges only and line up with t_state
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mreq_n <= 1'b1;
            iorq_n <= 1'b1;
            rd_n   <= 1'b1;
            wr_n   <= 1'b1;
            m1_n   <= 1'b1;
            rfsh_n <= 1'b1;
        end
        else
        begin
            mreq_n <= !((t_next != T_IDLE) && !kind_io(kind_next));
            iorq_n <= !((t_next != T_IDLE) && kind_io(kind_next));
            rd_n   <= !(kind_reads(kind_next) && (t_next inside {T_1, T_2, T_3}));
            wr_n   <= !(kind_writes(kind_next) && (t_next inside {T_2, T_3}));
            m1_n   <= !((kind_next == CYC_M1) && (t_next inside {T_1, T_2}));
            rfsh_n <= !(t_next == T_4);             // Only M1 cycles reach T_4
        end
    end

    // --------------------------------------------------
    // Pin block controls
    // --------------------------------------------------

    assign ctl_ab_we     = accept;                  // Address latched at E0
    assign ctl_db_we     = accept && kind_writes(cycle_kind);
    assign ctl_ab_pin_oe = busy;                    // T_1 up to the last T-state
    assign ctl_ab_rfsh   = (t_state == T_4);
    assign ctl_rfsh_inc  = (t_state == T_4);        // Counter steps at T_4 end
    assign ctl_db_pin_oe = kind_writes(kind_q) && (t_state inside {T_1, T_2, T_3});
    assign ctl_db_pin_re = kind_reads(kind_q) && (t_state == T_3);
    assign ctl_db_oe     = last_t;                  // data_pins filters writes out

endmodule

`default_nettype wire

// File: hdl/pins_pkg.sv
// Bus types and enums. Kind codes are fixed values since stimulus files use the raw numbers
`default_nettype none

`include "pins_macros.svh"

package pins_pkg;

    // --------------------------------------------------
    // Bus words
    // --------------------------------------------------

    typedef logic [`PINS_ADDR_W-1:0] addr_t;    // Address bus word
    typedef logic [`PINS_DATA_W-1:0] data_t;    // Data bus byte

    // --------------------------------------------------
    // Cycle kinds and T-states
    // --------------------------------------------------

    typedef enum logic [2:0]
    {
        CYC_MEM_RD = 3'd0,                      // Memory read
        CYC_MEM_WR = 3'd1,                      // Memory write
        CYC_IO_RD  = 3'd2,                      // I/O read, uses iorq_n
        CYC_IO_WR  = 3'd3,                      // I/O write, uses iorq_n
        CYC_M1     = 3'd4                       // Opcode fetch with refresh
    } cycle_kind_t;

    typedef enum logic [2:0]
    {
        T_IDLE = 3'd0,                          // No cycle in flight
        T_1    = 3'd1,                          // Address out
        T_2    = 3'd2,                          // Wait states repeat this one
        T_3    = 3'd3,                          // Read data sampled at its end
        T_4    = 3'd4                           // Refresh, M1 only
    } t_state_t;

endpackage

`default_nettype wire

// File: hdl/pins_macros.svh
// Bus widths for the pin blocks. PINS_RFSH_W must stay below PINS_ADDR_W
`ifndef PINS_MACROS_SVH
`define PINS_MACROS_SVH

// --------------------------------------------------
// Pin bus widths
// --------------------------------------------------

`define PINS_ADDR_W  16                 // Address pins A15..A0
`define PINS_DATA_W  8                  // Data pins D7..D0

// --------------------------------------------------
// Refresh field
// --------------------------------------------------

// The refresh counter sits in the low address bits during the refresh
// T-state of an M1 cycle and wraps around on its own width.
// Bits above it read as zero because there is no I register here.
`define PINS_RFSH_W  7                  // Low 7 bits, counts modulo 128

// Width of the zero fill above the refresh counter
`define PINS_RFSH_PAD_W  (`PINS_ADDR_W - `PINS_RFSH_W)

`endif
